// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - files:
      - logic/bus_pkg.sv
      - logic/mem_map_pkg.sv
      - logic/reset_sync.sv
      - logic/req_port.sv
      - logic/target_router.sv
      - logic/sram_bank.sv
      - logic/soc_fabric_top.sv
  - target: test
    files:
      - sim/clk_gen.sv
      - sim/tb_soc_fabric.sv

// ==== logic/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

    typedef enum logic {
        resp_okay   = 1'b0,
        resp_decerr = 1'b1
    } bus_resp_e;

    // single-beat command as presented by the requester
    typedef struct packed {
        bus_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } bus_req_t;

    // rdata is zero for writes and decode errors
    typedef struct packed {
        bus_resp_e           resp;
        logic [DATA_W-1:0]   rdata;
    } bus_rsp_t;

endpackage

// ==== logic/mem_map_pkg.sv ====
package mem_map_pkg;

    // byte address where the SRAM window starts, word aligned
    localparam logic [bus_pkg::ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;

    localparam int SRAM_WORDS = 64;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    localparam logic [bus_pkg::ADDR_W-1:0] SRAM_SIZE_BYTES = SRAM_WORDS * bus_pkg::STRB_W;

    // one access per cycle in which en is high
    typedef struct packed {
        logic                          en;
        logic                          we;
        logic [SRAM_IDX_W-1:0]         idx;
        logic [bus_pkg::DATA_W-1:0]    wdata;
        logic [bus_pkg::STRB_W-1:0]    wstrb;
    } sram_req_t;

endpackage

// ==== logic/req_port.sv ====
module req_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  bus_pkg::bus_req_t cmd,
    output logic              ack,
    output bus_pkg::bus_rsp_t rsp,
    output logic              cmd_valid,
    output bus_pkg::bus_req_t cmd_q,
    input  logic              rsp_valid,
    input  bus_pkg::bus_rsp_t rsp_in
);

    typedef enum logic [1:0] {
        port_idle,
        port_busy,
        port_ack,
        port_wait_low
    } port_state_e;

    port_state_e state_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= port_idle;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
        end else begin
            unique case (state_q)
                port_idle: begin
                    if (req) begin
                        state_q   <= port_busy;
                        cmd_valid <= 1'b1;
                    end
                end
                port_busy: begin
                    if (rsp_valid) begin
                        state_q   <= port_ack;
                        cmd_valid <= 1'b0;
                        ack       <= 1'b1;
                    end
                end
                // hold ack and the response until the requester lets go
                port_ack: begin
                    if (!req) begin
                        state_q <= port_wait_low;
                        ack     <= 1'b0;
                    end
                end
                // one cycle with ack low before the next command
                port_wait_low: begin
                    state_q <= port_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == port_idle && req) begin
            cmd_q <= cmd;
        end
        if (state_q == port_busy && rsp_valid) begin
            rsp <= rsp_in;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req);

    rsp_held_under_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> $stable(rsp));

endmodule

// ==== logic/reset_sync.sv ====
module reset_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic hartreset,
    input  logic ndmreset,
    output logic core_rst_n
);

    logic [1:0] sync_q;

    // async assert, release after two edges
    // a hart or system reset request pulls the core back into reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else if (hartreset) begin
            sync_q <= 2'b00;
        end else if (ndmreset) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign core_rst_n = sync_q[1];

endmodule

// ==== logic/soc_fabric_top.sv ====
module soc_fabric_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hartreset,
    input  logic              ndmreset,
    output logic              core_rst_n,
    input  logic              req,
    input  bus_pkg::bus_req_t cmd,
    output logic              ack,
    output bus_pkg::bus_rsp_t rsp
);

    logic                       cmd_valid;
    bus_pkg::bus_req_t          cmd_q;
    logic                       rsp_valid;
    bus_pkg::bus_rsp_t          route_rsp;
    mem_map_pkg::sram_req_t     mem_req;
    logic [bus_pkg::DATA_W-1:0] mem_rdata;

    reset_sync u_reset_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .hartreset  (hartreset),
        .ndmreset   (ndmreset),
        .core_rst_n (core_rst_n)
    );

    req_port u_req_port (
        .clk       (clk),
        .rst_n     (core_rst_n),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd_q     (cmd_q),
        .rsp_valid (rsp_valid),
        .rsp_in    (route_rsp)
    );

    target_router u_target_router (
        .clk       (clk),
        .rst_n     (core_rst_n),
        .cmd_valid (cmd_valid),
        .cmd_q     (cmd_q),
        .rsp_valid (rsp_valid),
        .rsp       (route_rsp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    // contents survive core resets
    sram_bank u_sram_bank (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

// ==== logic/sram_bank.sv ====
module sram_bank (
    input  logic                       clk,
    input  mem_map_pkg::sram_req_t     mem_req,
    output logic [bus_pkg::DATA_W-1:0] rdata
);

    localparam int BYTE_W = bus_pkg::DATA_W / bus_pkg::STRB_W;

    logic [bus_pkg::DATA_W-1:0] mem [mem_map_pkg::SRAM_WORDS];

    // byte lanes follow wstrb, unstrobed lanes keep their old value
    always_ff @(posedge clk) begin
        if (mem_req.en && mem_req.we) begin
            for (int b = 0; b < bus_pkg::STRB_W; b++) begin
                if (mem_req.wstrb[b]) begin
                    mem[mem_req.idx][b*BYTE_W +: BYTE_W] <= mem_req.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // read data is registered and held until the next read
    always_ff @(posedge clk) begin
        if (mem_req.en && !mem_req.we) begin
            rdata <= mem[mem_req.idx];
        end
    end

    idx_known_on_en: assert property (@(posedge clk)
        mem_req.en |-> !$isunknown(mem_req.idx));

endmodule

// ==== logic/target_router.sv ====
module target_router (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  bus_pkg::bus_req_t          cmd_q,
    output logic                       rsp_valid,
    output bus_pkg::bus_rsp_t          rsp,
    output mem_map_pkg::sram_req_t     mem_req,
    input  logic [bus_pkg::DATA_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        route_idle,
        route_issue,
        route_read,
        route_done
    } route_state_e;

    route_state_e                       state_q;
    logic [bus_pkg::ADDR_W-1:0]         addr_off;
    logic                               in_window;
    logic                               hit_q;
    logic                               mem_en_q;
    logic                               mem_we_q;
    logic [mem_map_pkg::SRAM_IDX_W-1:0] mem_idx_q;
    logic [bus_pkg::DATA_W-1:0]         mem_wdata_q;
    logic [bus_pkg::STRB_W-1:0]         mem_wstrb_q;

    // addresses below the base wrap to a large offset and miss
    assign addr_off  = cmd_q.addr - mem_map_pkg::SRAM_BASE;
    assign in_window = addr_off < mem_map_pkg::SRAM_SIZE_BYTES;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= route_idle;
            hit_q    <= 1'b0;
            mem_en_q <= 1'b0;
        end else begin
            mem_en_q <= 1'b0;
            unique case (state_q)
                route_idle: begin
                    if (cmd_valid) begin
                        state_q  <= route_issue;
                        hit_q    <= in_window;
                        mem_en_q <= in_window;
                    end
                end
                route_issue: state_q <= (hit_q && !mem_we_q) ? route_read : route_done;
                route_read:  state_q <= route_done;
                // port drops cmd_valid the cycle after the response
                route_done: begin
                    if (!cmd_valid) begin
                        state_q <= route_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == route_idle && cmd_valid) begin
            mem_we_q    <= (cmd_q.op == bus_pkg::op_write);
            mem_idx_q   <= addr_off[$clog2(bus_pkg::STRB_W) +: mem_map_pkg::SRAM_IDX_W];
            mem_wdata_q <= cmd_q.wdata;
            mem_wstrb_q <= cmd_q.wstrb;
        end
    end

    assign mem_req = '{en: mem_en_q, we: mem_we_q, idx: mem_idx_q,
                       wdata: mem_wdata_q, wstrb: mem_wstrb_q};

    // writes and misses answer in the issue cycle, reads once the SRAM data is out
    always_comb begin
        rsp_valid = (state_q == route_issue && !(hit_q && !mem_we_q)) ||
                    (state_q == route_read);
        rsp.resp  = hit_q ? bus_pkg::resp_okay : bus_pkg::resp_decerr;
        rsp.rdata = (state_q == route_read) ? mem_rdata : '0;
    end

    rsp_within_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> cmd_valid);

    en_only_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.en |-> (cmd_valid && in_window));

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low over the first five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

// ==== sim/tb_soc_fabric.sv ====
module tb_soc_fabric;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rst_n;
    logic hartreset;
    logic ndmreset;
    logic core_rst_n;
    logic req;
    logic ack;
    bus_pkg::bus_req_t cmd;
    bus_pkg::bus_rsp_t rsp;
    bus_pkg::bus_rsp_t exp_rsp;
    integer seed = 32'hd6496bb0;
    int unsigned hold_cycles;
    logic [bus_pkg::DATA_W-1:0] ref_mem [mem_map_pkg::SRAM_WORDS];

    clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    soc_fabric_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .hartreset  (hartreset),
        .ndmreset   (ndmreset),
        .core_rst_n (core_rst_n),
        .req        (req),
        .cmd        (cmd),
        .ack        (ack),
        .rsp        (rsp)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    in_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!ack && !core_rst_n))
        else stop_run($sformatf("mismatch at %0t: ack or core_rst_n high during reset", $time));

    core_up_after_rst: assert property (@(posedge clk)
        $rose(rst_n) |-> !core_rst_n ##1 !core_rst_n ##1 core_rst_n)
        else stop_run($sformatf("mismatch at %0t: core_rst_n release after rst_n", $time));

    core_down_on_request: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hartreset || ndmreset) |=> !core_rst_n)
        else stop_run($sformatf("mismatch at %0t: core_rst_n stayed high on request", $time));

    core_up_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hartreset || ndmreset) |-> !core_rst_n ##1 !core_rst_n ##1 core_rst_n)
        else stop_run($sformatf("mismatch at %0t: core_rst_n release after request", $time));

    ack_rise_with_req: assert property (@(posedge clk) disable iff (!core_rst_n)
        $rose(ack) |-> req)
        else stop_run("ack rose while req was low");

    ack_latency: assert property (@(posedge clk) disable iff (!core_rst_n)
        $rose(req) |-> ##[3:5] ack)
        else stop_run("ack did not rise 2 to 4 cycles after req");

    ack_held_for_req: assert property (@(posedge clk) disable iff (!core_rst_n)
        (ack && req) |=> ack)
        else stop_run("ack dropped while req was still high");

    ack_drops_after_req: assert property (@(posedge clk) disable iff (!core_rst_n)
        (ack && !req) |=> !ack)
        else stop_run("ack stayed high after req dropped");

    rsp_stable_under_ack: assert property (@(posedge clk) disable iff (!core_rst_n)
        (ack && $past(ack)) |-> $stable(rsp))
        else stop_run("rsp changed while ack was high");

    rsp_matches_model: assert property (@(posedge clk) disable iff (!core_rst_n)
        $rose(ack) |-> (rsp == exp_rsp))
        else stop_run($sformatf("mismatch at %0t: rsp %h, expected %h",
                                $time, $sampled(rsp), $sampled(exp_rsp)));

    function automatic logic [bus_pkg::DATA_W-1:0] merge_bytes(
        input logic [bus_pkg::DATA_W-1:0] old_word,
        input logic [bus_pkg::DATA_W-1:0] new_word,
        input logic [bus_pkg::STRB_W-1:0] strb
    );
        logic [bus_pkg::DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < bus_pkg::STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [bus_pkg::ADDR_W-1:0] word_addr(input int unsigned idx);
        return mem_map_pkg::SRAM_BASE + idx * bus_pkg::STRB_W;
    endfunction

    // flop outputs are read right after the edge, before that edge updates them
    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (ack !== level && n < 20);
        if (ack !== level) begin
            stop_run($sformatf("ack did not reach %b within 20 cycles", level));
        end
    endtask

    task automatic wait_core_up();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (core_rst_n !== 1'b1 && n < 20);
        if (core_rst_n !== 1'b1) begin
            stop_run("core reset was not released within 20 cycles");
        end
    endtask

    task automatic run_access(
        input bus_pkg::bus_op_e           op,
        input logic [bus_pkg::ADDR_W-1:0] addr,
        input logic [bus_pkg::DATA_W-1:0] wdata,
        input logic [bus_pkg::STRB_W-1:0] wstrb
    );
        bus_pkg::bus_rsp_t          expected;
        logic [bus_pkg::ADDR_W-1:0] offset;
        int unsigned                idx;
        offset = addr - mem_map_pkg::SRAM_BASE;
        idx = offset / bus_pkg::STRB_W;
        expected.rdata = '0;
        if (addr < mem_map_pkg::SRAM_BASE || offset >= mem_map_pkg::SRAM_SIZE_BYTES) begin
            expected.resp = bus_pkg::resp_decerr;
        end else if (op == bus_pkg::op_write) begin
            expected.resp = bus_pkg::resp_okay;
            ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, wstrb);
        end else begin
            expected.resp = bus_pkg::resp_okay;
            expected.rdata = ref_mem[idx];
        end
        @(posedge clk);
        cmd <= '{op: op, addr: addr, wdata: wdata, wstrb: wstrb};
        exp_rsp <= expected;
        req <= 1'b1;
        wait_ack(1'b1);
        // requester keeps req high a little longer as back-pressure
        repeat (hold_cycles) @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic pulse_reset_request(input logic hart);
        @(posedge clk);
        if (hart) begin
            hartreset <= 1'b1;
        end else begin
            ndmreset <= 1'b1;
        end
        @(posedge clk);
        hartreset <= 1'b0;
        ndmreset <= 1'b0;
        wait_core_up();
    endtask

    initial begin
        int unsigned                idx;
        logic [bus_pkg::DATA_W-1:0] data;
        logic [bus_pkg::STRB_W-1:0] strb;
        req = 1'b0;
        cmd = '0;
        exp_rsp = '0;
        hartreset = 1'b0;
        ndmreset = 1'b0;
        hold_cycles = 0;
        wait_core_up();
        // fill pattern built from the full byte address
        for (int i = 0; i < mem_map_pkg::SRAM_WORDS; i++) begin
            run_access(bus_pkg::op_write, word_addr(i), {word_addr(i), ~word_addr(i)}, 8'hff);
            run_access(bus_pkg::op_read, word_addr(i), '0, '0);
        end
        repeat (24) begin
            idx = $unsigned($random(seed)) % mem_map_pkg::SRAM_WORDS;
            data = {$random(seed), $random(seed)};
            strb = $random(seed);
            hold_cycles = $unsigned($random(seed)) % 4;
            run_access(bus_pkg::op_write, word_addr(idx), data, strb);
            run_access(bus_pkg::op_read, word_addr(idx), '0, '0);
        end
        // first miss aliases word 5 if the upper bound were ignored
        run_access(bus_pkg::op_write, word_addr(mem_map_pkg::SRAM_WORDS + 5), '1, 8'hff);
        run_access(bus_pkg::op_read, word_addr(mem_map_pkg::SRAM_WORDS + 5), '0, '0);
        run_access(bus_pkg::op_write, mem_map_pkg::SRAM_BASE - 8, '1, 8'hff);
        run_access(bus_pkg::op_read, 32'h0000_1000, '0, '0);
        run_access(bus_pkg::op_read, word_addr(5), '0, '0);
        run_access(bus_pkg::op_read, word_addr(63), '0, '0);
        pulse_reset_request(1'b1);
        pulse_reset_request(1'b0);
        for (int i = 0; i < mem_map_pkg::SRAM_WORDS; i += 7) begin
            run_access(bus_pkg::op_read, word_addr(i), '0, '0);
        end
        $display("Simulation completed successfully");
        $finish;
    end
endmodule

// ==== soc_fabric.f ====
logic/bus_pkg.sv
logic/mem_map_pkg.sv
logic/reset_sync.sv
logic/req_port.sv
logic/target_router.sv
logic/sram_bank.sv
logic/soc_fabric_top.sv
sim/clk_gen.sv
sim/tb_soc_fabric.sv
